// File: hdl/const_extract.sv
// Line constant extractor
`timescale 1ns/1ps

module const_extract import qd_pkg::*; (
	input logic [$clog2(CONST_SLOTS)-1:0] slot,
	input logic [1:0] size,
	input logic [LINE_BITS-1:0] cline,
	output logic [63:0] cnst
);

	logic [$clog2(CONST_SLOTS)-1:0] next_slot;
	logic [SLOT_BITS-1:0] lo_word;
	logic [SLOT_BITS-1:0] hi_word;

	always_comb
	begin
		// The upper half of a 64-bit constant wraps to slot 0 at the line end
		next_slot = slot + 1'b1;
		lo_word = cline[slot * SLOT_BITS +: SLOT_BITS];
		hi_word = cline[next_slot * SLOT_BITS +: SLOT_BITS];
		case (size)
		2'd1:	cnst = {{48{lo_word[15]}}, lo_word[15:0]};
		2'd2:	cnst = {{32{lo_word[31]}}, lo_word};
		2'd3:	cnst = {hi_word, lo_word};
		// No constant present
		default:	cnst = 64'd0;
		endcase
	end

endmodule

// File: hdl/decode_const.sv
// Instruction constant decoder
`timescale 1ns/1ps

module decode_const import qd_pkg::*; (
	input logic [LINE_BITS-1:0] cline,
	input instruction_t ins,
	output logic [63:0] imma,
	output logic [63:0] immb,
	output logic [63:0] immc,
	output logic has_imma,
	output logic has_immb,
	output logic has_immc
);

	logic [11:0] pos;
	logic [5:0] isz;
	logic [63:0] cnst [3];
	logic [63:0] wide [3];
	// Line constant, or its widened form for 16- and 32-bit floats
	logic [63:0] flt [3];

	assign pos = fn_const_pos(ins);
	assign isz = fn_const_size(ins);

	// One extractor and one widener per constant A, B and C
	for (genvar k = 0; k < 3; k++)
	begin : g_const
		const_extract u_extract (
			.slot(pos[4*k +: 4]),
			.size(isz[2*k +: 2]),
			.cline(cline),
			.cnst(cnst[k])
		);

		fp_widen u_widen (
			.src(cnst[k][31:0]),
			.is_half(isz[2*k +: 2] == 2'd1),
			.dst(wide[k])
		);

		assign flt[k] = (isz[2*k +: 2] == 2'd1 || isz[2*k +: 2] == 2'd2) ? wide[k] : cnst[k];
	end

	always_comb
	begin
		imma = 64'd0;
		immb = 64'd0;
		immc = 64'd0;
		has_imma = 1'b0;
		has_immb = 1'b0;
		has_immc = 1'b0;
		case (ins.opcode)
		OP_ADDI, OP_CMPI, OP_MULI, OP_ANDI, OP_ORI, OP_XORI:
		begin
			imma = cnst[0];
			immb = cnst[1];
			immc = cnst[2];
			has_imma = fn_has_const_rs1(ins);
			has_immb = fn_has_const_rs2(ins);
			has_immc = fn_has_const_rs3(ins);
		end
		OP_FLTI:
		begin
			imma = flt[0];
			immb = flt[1];
			immc = flt[2];
			has_imma = fn_has_const_rs1(ins);
			has_immb = fn_has_const_rs2(ins);
			has_immc = fn_has_const_rs3(ins);
		end
		// Only a 7-bit CSR number is carried
		OP_CSR:
			immb = {57'd0, ins[22:16]};
		// Branch displacements are word counts, hence the scale by 4
		OP_B0, OP_B1:
		begin
			immb = fn_has_ex_const(ins) ? cnst[0] : {{38{ins[30]}}, ins[30:7], 2'b00};
			has_immb = 1'b1;
		end
		OP_BCC0, OP_BCC1:
		begin
			immb = fn_has_ex_const(ins) ? cnst[0] :
				{{52{ins[30]}}, ins[30:29], ins[16:9], 2'b00};
			has_immb = !fn_has_ex_const(ins);
		end
		OP_LOAD, OP_LDW, OP_STORE, OP_STW:
		begin
			immb = fn_has_ex_const(ins) ? cnst[0] : {{50{ins[30]}}, ins[30:17]};
			has_immb = !fn_has_ex_const(ins);
		end
		// Store-immediate also carries the stored value as C
		OP_STI:
		begin
			immb = fn_has_ex_const(ins) ? cnst[0] : {{50{ins[30]}}, ins[30:17]};
			immc = cnst[1];
			has_immb = !fn_has_ex_const(ins);
			has_immc = 1'b1;
		end
		OP_FENCE:
		begin
			immb = {48'd0, ins[23:8]};
			has_immb = 1'b1;
		end
		default:
			immb = 64'd0;
		endcase
	end

endmodule

// File: hdl/decode_lane.sv
// Constant decode lane
`timescale 1ns/1ps

module decode_lane import qd_pkg::*; (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input instruction_t ins,
	input logic [LINE_IDX_BITS-1:0] idx,
	output logic busy,
	output logic out_valid,
	output logic [63:0] imma,
	output logic [63:0] immb,
	output logic [63:0] immc,
	output logic has_imma,
	output logic has_immb,
	output logic has_immc,
	line_rd_if.lane rd
);

	typedef enum logic [1:0] {
		LANE_IDLE,
		LANE_WAIT_GNT,
		LANE_LINE
	} lane_state_t;

	lane_state_t state;
	instruction_t ins_q;
	logic [LINE_IDX_BITS-1:0] idx_q;
	logic [63:0] dec_a, dec_b, dec_c;
	logic dec_has_a, dec_has_b, dec_has_c;

	// ==============================
	// Sequencer
	// ==============================

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= LANE_IDLE;
		else
			case (state)
			LANE_IDLE:
				if (in_valid)
					state <= LANE_WAIT_GNT;
			LANE_WAIT_GNT:
				if (rd.gnt)
					state <= LANE_LINE;
			// The line is on the bus for exactly this one cycle
			default:
				state <= LANE_IDLE;
			endcase
	end

	// Instruction and index are captured only when a new request is taken
	always_ff @(posedge clk)
	begin
		if (state == LANE_IDLE && in_valid)
		begin
			ins_q <= ins;
			idx_q <= idx;
		end
	end

	assign busy = state != LANE_IDLE;
	assign rd.req = state == LANE_WAIT_GNT;
	assign rd.idx = idx_q;

	// ==============================
	// Decode and result register
	// ==============================

	decode_const u_decode (
		.cline(rd.line),
		.ins(ins_q),
		.imma(dec_a),
		.immb(dec_b),
		.immc(dec_c),
		.has_imma(dec_has_a),
		.has_immb(dec_has_b),
		.has_immc(dec_has_c)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= state == LANE_LINE;
	end

	always_ff @(posedge clk)
	begin
		if (state == LANE_LINE)
		begin
			imma <= dec_a;
			immb <= dec_b;
			immc <= dec_c;
			has_imma <= dec_has_a;
			has_immb <= dec_has_b;
			has_immc <= dec_has_c;
		end
	end

endmodule

// File: hdl/fp_widen.sv
// Half and single to double widening
`timescale 1ns/1ps

module fp_widen import qd_pkg::*; (
	input logic [31:0] src,
	input logic is_half,
	output logic [63:0] dst
);

	logic sgn;
	logic [7:0] exp_in;
	logic [22:0] man_in;
	logic exp_ones;
	logic [10:0] exp_out;

	always_comb
	begin
		// Bring both formats to a common single-like layout first
		if (is_half)
		begin
			sgn = src[15];
			exp_in = {3'b000, src[14:10]};
			// Half mantissa sits at the top of the 23-bit field
			man_in = {src[9:0], 13'd0};
			exp_ones = &src[14:10];
		end
		else
		begin
			sgn = src[31];
			exp_in = src[30:23];
			man_in = src[22:0];
			exp_ones = &src[30:23];
		end

		// Re-bias to 1023, that is +1008 from half and +896 from single
		exp_out = {3'b000, exp_in} + (is_half ? 11'd1008 : 11'd896);

		// Zero and denormal inputs both give a signed zero
		if (exp_in == 8'd0)
			dst = {sgn, 63'd0};
		// Infinity keeps a zero mantissa, NaN keeps a non-zero one
		else if (exp_ones)
			dst = {sgn, 11'h7ff, man_in, 29'd0};
		else
			dst = {sgn, exp_out, man_in, 29'd0};
	end

endmodule

// File: hdl/line_arbiter.sv
// Round-robin line buffer arbiter
`timescale 1ns/1ps

module line_arbiter import qd_pkg::*; (
	input logic clk,
	input logic reset,
	input logic wr_en,
	input logic [LINE_IDX_BITS-1:0] wr_idx,
	input logic [LINE_BITS-1:0] wr_line,
	line_rd_if.arbiter rd0,
	line_rd_if.arbiter rd1
);

	logic [LINE_BITS-1:0] lines [LINE_COUNT];
	logic [N_LANES-1:0] avail;
	logic [N_LANES-1:0] gnt;
	// Lane that wins a tie on the next grant
	logic [$clog2(N_LANES)-1:0] prio;
	logic [$clog2(N_LANES)-1:0] pick;
	logic [LINE_IDX_BITS-1:0] rd_idx;
	logic [LINE_BITS-1:0] line_q;

	// ==============================
	// Grant selection
	// ==============================

	always_comb
	begin
		// A lane still shows req during its grant cycle, so mask it
		avail[0] = rd0.req && !gnt[0];
		avail[1] = rd1.req && !gnt[1];
		if (avail[prio])
			pick = prio;
		else
			pick = ~prio;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			gnt <= '0;
			prio <= '0;
		end
		else
		begin
			gnt <= '0;
			if (|avail)
			begin
				gnt[pick] <= 1'b1;
				prio <= ~pick;
			end
		end
	end

	// Index of the winner travels with the grant
	always_ff @(posedge clk)
	begin
		if (|avail)
			rd_idx <= pick ? rd1.idx : rd0.idx;
	end

	// ==============================
	// Line storage
	// ==============================

	// A write on the grant cycle lands after the read, so the old line is seen
	always_ff @(posedge clk)
	begin
		if (wr_en)
			lines[wr_idx] <= wr_line;
		if (|gnt)
			line_q <= lines[rd_idx];
	end

	assign rd0.gnt = gnt[0];
	assign rd1.gnt = gnt[1];
	assign rd0.line = line_q;
	assign rd1.line = line_q;

endmodule

// File: hdl/line_rd_if.sv
// Line buffer read port
`timescale 1ns/1ps

interface line_rd_if import qd_pkg::*; ();

	// Level from the lane, held until the grant is seen
	logic req;
	logic [LINE_IDX_BITS-1:0] idx;
	// Single-cycle grant pulse from the arbiter
	logic gnt;
	// Valid on the cycle after gnt
	logic [LINE_BITS-1:0] line;

	modport lane (
		output req,
		output idx,
		input gnt,
		input line
	);

	modport arbiter (
		input req,
		input idx,
		output gnt,
		output line
	);

endinterface

// File: hdl/qd_pkg.sv
// Constant decode shared definitions

package qd_pkg;

	// ==============================
	// Sizes
	// ==============================

	localparam int LINE_BITS = 512;
	localparam int LINE_COUNT = 4;
	localparam int LINE_IDX_BITS = 2;
	// A line is cut into 32-bit constant slots
	localparam int CONST_SLOTS = 16;
	localparam int SLOT_BITS = LINE_BITS / CONST_SLOTS;
	localparam int N_LANES = 2;

	// ==============================
	// Instruction format
	// ==============================

	// Only the opcode classes handled by the constant decoder are kept
	typedef enum logic [6:0] {
		OP_ADDI  = 7'd4,
		OP_CMPI  = 7'd5,
		OP_MULI  = 7'd6,
		OP_CSR   = 7'd7,
		OP_ANDI  = 7'd8,
		OP_ORI   = 7'd9,
		OP_XORI  = 7'd10,
		OP_FLTI  = 7'd12,
		OP_B0    = 7'd32,
		OP_B1    = 7'd33,
		OP_BCC0  = 7'd34,
		OP_BCC1  = 7'd35,
		OP_LOAD  = 7'd40,
		OP_LDW   = 7'd41,
		OP_STORE = 7'd48,
		OP_STW   = 7'd49,
		OP_STI   = 7'd50,
		OP_FENCE = 7'd127
	} opcode_t;

	// Form 3'b100 marks an extension constant in the line after the word
	typedef struct packed {
		logic [2:0] form;
		logic [21:0] fields;
		opcode_t opcode;
	} instruction_t;

	// ==============================
	// Constant field decoding
	// ==============================

	// Three 4-bit slot numbers, constant A in the low nibble
	function automatic logic [11:0] fn_const_pos(instruction_t ins);
		return {ins[18:15], ins[14:11], ins[10:7]};
	endfunction

	// Three 2-bit size codes: none, 16, 32 and 64 bits
	function automatic logic [5:0] fn_const_size(instruction_t ins);
		return ins[24:19];
	endfunction

	// An operand is a constant when its size code is not zero
	function automatic logic fn_has_const_rs1(instruction_t ins);
		return ins[20:19] != 2'd0;
	endfunction

	function automatic logic fn_has_const_rs2(instruction_t ins);
		return ins[22:21] != 2'd0;
	endfunction

	function automatic logic fn_has_const_rs3(instruction_t ins);
		return ins[24:23] != 2'd0;
	endfunction

	function automatic logic fn_has_ex_const(instruction_t ins);
		return ins.form == 3'b100;
	endfunction

endpackage

// File: hdl/qd_top.sv
// Two-lane constant decode top
`timescale 1ns/1ps

module qd_top import qd_pkg::*; (
	input logic clk,
	input logic reset,
	input logic wr_en,
	input logic [LINE_IDX_BITS-1:0] wr_idx,
	input logic [LINE_BITS-1:0] wr_line,
	input logic in_valid_0,
	input instruction_t ins_0,
	input logic [LINE_IDX_BITS-1:0] idx_0,
	output logic busy_0,
	output logic out_valid_0,
	output logic [63:0] imma_0,
	output logic [63:0] immb_0,
	output logic [63:0] immc_0,
	output logic has_imma_0,
	output logic has_immb_0,
	output logic has_immc_0,
	input logic in_valid_1,
	input instruction_t ins_1,
	input logic [LINE_IDX_BITS-1:0] idx_1,
	output logic busy_1,
	output logic out_valid_1,
	output logic [63:0] imma_1,
	output logic [63:0] immb_1,
	output logic [63:0] immc_1,
	output logic has_imma_1,
	output logic has_immb_1,
	output logic has_immc_1
);

	// One read port per lane into the shared line buffer
	line_rd_if rd0_if ();
	line_rd_if rd1_if ();

	line_arbiter u_arbiter (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_line(wr_line),
		.rd0(rd0_if.arbiter),
		.rd1(rd1_if.arbiter)
	);

	decode_lane u_lane0 (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid_0),
		.ins(ins_0),
		.idx(idx_0),
		.busy(busy_0),
		.out_valid(out_valid_0),
		.imma(imma_0),
		.immb(immb_0),
		.immc(immc_0),
		.has_imma(has_imma_0),
		.has_immb(has_immb_0),
		.has_immc(has_immc_0),
		.rd(rd0_if.lane)
	);

	decode_lane u_lane1 (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid_1),
		.ins(ins_1),
		.idx(idx_1),
		.busy(busy_1),
		.out_valid(out_valid_1),
		.imma(imma_1),
		.immb(immb_1),
		.immc(immc_1),
		.has_imma(has_imma_1),
		.has_immb(has_immb_1),
		.has_immc(has_immc_1),
		.rd(rd1_if.lane)
	);

endmodule

// File: project.f
hdl/qd_pkg.sv
hdl/line_rd_if.sv
hdl/const_extract.sv
hdl/fp_widen.sv
hdl/decode_const.sv
hdl/decode_lane.sv
hdl/line_arbiter.sv
hdl/qd_top.sv
test/decode_chk.sv
test/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the constant decode simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_top -o sim_tb

# Keep running past assertion failures so the testbench prints its summary
obj_dir/sim_tb +verilator+error+limit+100000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: test/decode_chk.sv
// Constant decode checker
`timescale 1ns/1ps

module decode_chk import qd_pkg::*; (
	input logic clk,
	input logic reset,
	input logic wr_en,
	input logic [LINE_IDX_BITS-1:0] wr_idx,
	input logic [LINE_BITS-1:0] wr_line,
	input logic [N_LANES-1:0] in_valid,
	input instruction_t [N_LANES-1:0] ins,
	input logic [N_LANES-1:0][LINE_IDX_BITS-1:0] idx,
	input logic [N_LANES-1:0] busy,
	input logic [N_LANES-1:0] out_valid,
	input logic [N_LANES-1:0][63:0] imma,
	input logic [N_LANES-1:0][63:0] immb,
	input logic [N_LANES-1:0][63:0] immc,
	input logic [N_LANES-1:0] has_a,
	input logic [N_LANES-1:0] has_b,
	input logic [N_LANES-1:0] has_c,
	input logic [N_LANES-1:0] req,
	input logic [N_LANES-1:0] gnt
);

	// Copy of the line buffer as the outside world wrote it
	logic [LINE_BITS-1:0] shadow [LINE_COUNT];
	// Lane that received the most recent grant
	logic last_q;
	int unsigned fails;

	// ==============================
	// Expected values
	// ==============================

	// Slot constant, sign-extended by its size code; 64-bit wraps to slot 0
	function automatic logic [63:0] slot_val(logic [LINE_BITS-1:0] line, logic [3:0] slot,
		logic [1:0] size);
		logic [31:0] w0;
		logic [31:0] w1;
		logic [3:0] nxt;
		nxt = slot + 4'd1;
		w0 = line[32*slot +: 32];
		w1 = line[32*nxt +: 32];
		case (size)
		2'd1:	return 64'($signed(w0[15:0]));
		2'd2:	return 64'($signed(w0));
		2'd3:	return {w1, w0};
		default:	return 64'd0;
		endcase
	endfunction

	// Constant k of an instruction (0 is A, 1 is B, 2 is C)
	function automatic logic [63:0] const_of(logic [LINE_BITS-1:0] line, instruction_t i,
		int k);
		logic [11:0] p;
		logic [5:0] s;
		p = fn_const_pos(i);
		s = fn_const_size(i);
		return slot_val(line, p[4*k +: 4], s[2*k +: 2]);
	endfunction

	// Only the float facts that hold exactly are checked here
	function automatic logic flt_ok(logic [LINE_BITS-1:0] line, instruction_t i, int k,
		logic [63:0] dst);
		logic [11:0] p;
		logic [5:0] s;
		logic [31:0] w;
		logic half;
		logic sgn;
		logic zero;
		logic ok;
		p = fn_const_pos(i);
		s = fn_const_size(i);
		w = line[32*p[4*k +: 4] +: 32];
		half = s[2*k +: 2] == 2'd1;
		sgn = half ? w[15] : w[31];
		zero = half ? (w[14:10] == 5'd0) : (w[30:23] == 8'd0);
		ok = dst[63] == sgn;
		if (zero)
			ok = ok && dst[62:0] == 63'd0;
		// Plus and minus one and two are exact in every format
		if ((half && w[15:0] == 16'h3c00) || (!half && w == 32'h3f80_0000))
			ok = ok && dst == 64'h3ff0_0000_0000_0000;
		if ((half && w[15:0] == 16'hc000) || (!half && w == 32'hc000_0000))
			ok = ok && dst == 64'hc000_0000_0000_0000;
		if (s[2*k +: 2] == 2'd0 || s[2*k +: 2] == 2'd3)
			ok = 1'b1;
		return ok;
	endfunction

	function automatic logic is_alu(instruction_t i);
		return i.opcode inside {OP_ADDI, OP_CMPI, OP_MULI, OP_ANDI, OP_ORI, OP_XORI};
	endfunction

	// Classes whose B operand comes from the word itself outside extension form
	function automatic logic in_word(instruction_t i);
		return !fn_has_ex_const(i) && i.opcode inside {OP_B0, OP_B1, OP_BCC0, OP_BCC1,
			OP_LOAD, OP_LDW, OP_STORE, OP_STW, OP_STI};
	endfunction

	function automatic logic [63:0] word_imm(instruction_t i);
		logic signed [63:0] v;
		case (i.opcode)
		OP_B0, OP_B1:
			v = $signed(i[30:7]);
		OP_BCC0, OP_BCC1:
			v = $signed({i[30:29], i[16:9]});
		default:
			v = $signed(i[30:17]);
		endcase
		// Branch displacements count words
		if (i.opcode inside {OP_B0, OP_B1, OP_BCC0, OP_BCC1})
			v = v * 4;
		return v;
	endfunction

	// ==============================
	// Tracking state
	// ==============================

	always_ff @(posedge clk)
	begin
		if (wr_en)
			shadow[wr_idx] <= wr_line;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			last_q <= 1'b1;
		else if (gnt[0])
			last_q <= 1'b0;
		else if (gnt[1])
			last_q <= 1'b1;
	end

	initial fails = 0;

	// Arbitration rules shared by both lanes
	a_one_gnt: assert property (@(posedge clk) !(gnt[0] && gnt[1]))
	else
	begin
		$error("** Error @%0t: both lanes granted in one cycle", $time);
		fails++;
	end

	a_alternate: assert property (@(posedge clk) disable iff (reset)
		(req == 2'b11 && gnt == 2'b00) |=> gnt[!last_q])
	else
	begin
		$error("** Error @%0t: contended grant went to the lane granted last", $time);
		fails++;
	end

	a_reset: assert property (@(posedge clk)
		$fell(reset) |-> busy == '0 && out_valid == '0 && req == '0 && gnt == '0)
	else
	begin
		$error("** Error @%0t: lane or arbiter active right after reset", $time);
		fails++;
	end

	for (genvar n = 0; n < N_LANES; n++)
	begin : g_lane
		instruction_t ins_c;
		logic [LINE_IDX_BITS-1:0] idx_c;
		// Cycles since capture; zero while the lane is idle
		logic [2:0] age;
		// Set when the other lane took the line while this one waited
		logic lost;
		logic [1:0] wait_cnt;
		logic [LINE_BITS-1:0] cline;

		assign cline = shadow[idx_c];

		always_ff @(posedge clk)
		begin
			if (reset)
			begin
				age <= '0;
				lost <= 1'b0;
				wait_cnt <= '0;
			end
			else
			begin
				if (out_valid[n])
					age <= '0;
				else if (age != 3'd0)
					age <= age + 3'd1;
				if (req[n] && gnt[1-n])
					lost <= 1'b1;
				// A new capture wins over the end of the previous one
				if (in_valid[n] && !busy[n])
				begin
					age <= 3'd1;
					lost <= 1'b0;
					ins_c <= ins[n];
					idx_c <= idx[n];
				end
				wait_cnt <= (req[n] && !gnt[n]) ? wait_cnt + 2'd1 : 2'd0;
			end
		end

		a_wait: assert property (@(posedge clk) disable iff (reset)
			req[n] && !gnt[n] |-> wait_cnt < 2'd2)
		else
		begin
			$error("** Error @%0t: lane %0d request not granted in 2 cycles", $time, n);
			fails++;
		end

		a_latency: assert property (@(posedge clk) disable iff (reset)
			out_valid[n] |-> age == 3'd4 || (lost && age == 3'd5))
		else
		begin
			$error("** Error @%0t: lane %0d result after %0d cycles", $time, n, age);
			fails++;
		end

		a_busy: assert property (@(posedge clk) disable iff (reset)
			out_valid[n] == $fell(busy[n]))
		else
		begin
			$error("** Error @%0t: lane %0d busy and out_valid out of step", $time, n);
			fails++;
		end

		a_word: assert property (@(posedge clk) disable iff (reset)
			out_valid[n] && in_word(ins_c) |-> immb[n] == word_imm(ins_c))
		else
		begin
			$error("** Error @%0t: lane %0d immb differs from the in-word field", $time, n);
			fails++;
		end

		a_alu: assert property (@(posedge clk) disable iff (reset)
			out_valid[n] && is_alu(ins_c) |->
			imma[n] == const_of(cline, ins_c, 0) && immb[n] == const_of(cline, ins_c, 1) &&
			immc[n] == const_of(cline, ins_c, 2) && has_a[n] == fn_has_const_rs1(ins_c) &&
			has_b[n] == fn_has_const_rs2(ins_c) && has_c[n] == fn_has_const_rs3(ins_c))
		else
		begin
			$error("** Error @%0t: lane %0d line constants or flags wrong", $time, n);
			fails++;
		end

		a_float: assert property (@(posedge clk) disable iff (reset)
			out_valid[n] && ins_c.opcode == OP_FLTI |->
			flt_ok(cline, ins_c, 0, imma[n]) && flt_ok(cline, ins_c, 1, immb[n]) &&
			flt_ok(cline, ins_c, 2, immc[n]))
		else
		begin
			$error("** Error @%0t: lane %0d float constant widened wrongly", $time, n);
			fails++;
		end
	end

endmodule

bind qd_top decode_chk chk_i (
	.clk(clk),
	.reset(reset),
	.wr_en(wr_en),
	.wr_idx(wr_idx),
	.wr_line(wr_line),
	.in_valid({in_valid_1, in_valid_0}),
	.ins({ins_1, ins_0}),
	.idx({idx_1, idx_0}),
	.busy({busy_1, busy_0}),
	.out_valid({out_valid_1, out_valid_0}),
	.imma({imma_1, imma_0}),
	.immb({immb_1, immb_0}),
	.immc({immc_1, immc_0}),
	.has_a({has_imma_1, has_imma_0}),
	.has_b({has_immb_1, has_immb_0}),
	.has_c({has_immc_1, has_immc_0}),
	.req({rd1_if.req, rd0_if.req}),
	.gnt({rd1_if.gnt, rd0_if.gnt})
);

// File: test/tb_top.sv
// Constant decode testbench
`timescale 1ns/1ps

module tb_top import qd_pkg::*; ();

	localparam logic [31:0] SEED = 32'h6ae2_0a57;
	localparam int N_FIXED = 12;
	localparam int N_RANDOM = 200;
	// Each random round can put an instruction on both lanes
	localparam int WATCH_CYCLES = 300 * (N_FIXED + 2 * N_RANDOM) + 40;
	localparam opcode_t OPS [18] = '{OP_ADDI, OP_CMPI, OP_MULI, OP_CSR, OP_ANDI, OP_ORI,
		OP_XORI, OP_FLTI, OP_B0, OP_B1, OP_BCC0, OP_BCC1, OP_LOAD, OP_LDW, OP_STORE,
		OP_STW, OP_STI, OP_FENCE};

	logic clk;
	logic reset;
	logic wr_en;
	logic [LINE_IDX_BITS-1:0] wr_idx;
	logic [LINE_BITS-1:0] wr_line;
	logic in_valid_0, in_valid_1;
	instruction_t ins_0, ins_1;
	logic [LINE_IDX_BITS-1:0] idx_0, idx_1;
	logic busy_0, busy_1;
	logic out_valid_0, out_valid_1;
	logic [63:0] imma_0, immb_0, immc_0;
	logic [63:0] imma_1, immb_1, immc_1;
	logic has_imma_0, has_immb_0, has_immc_0;
	logic has_imma_1, has_immb_1, has_immc_1;

	qd_top dut_i (.*);

	always #50 clk = ~clk;

	// ==============================
	// Helpers
	// ==============================

	// Fields are {form, spare, sizes C B A, slots C B A, opcode}
	function automatic instruction_t make_ins(opcode_t op, logic [2:0] form, logic [5:0] sz,
		logic [11:0] pos);
		return {form, 4'd0, sz, pos, op};
	endfunction

	function automatic instruction_t rand_ins();
		instruction_t i;
		i = instruction_t'($urandom);
		i.opcode = OPS[5'($urandom % 18)];
		if ($urandom % 4 == 0)
			i.form = 3'b100;
		return i;
	endfunction

	function automatic logic [LINE_BITS-1:0] rand_line();
		logic [LINE_BITS-1:0] l;
		for (int s = 0; s < CONST_SLOTS; s++)
			l[32*s +: 32] = $urandom;
		return l;
	endfunction

	// Called on a falling edge; waits until every chosen lane is idle
	task automatic issue(input bit go0, input instruction_t i0, input logic [1:0] x0,
		input bit go1, input instruction_t i1, input logic [1:0] x1);
		while ((go0 && busy_0) || (go1 && busy_1))
			@(negedge clk);
		in_valid_0 = go0;
		ins_0 = i0;
		idx_0 = x0;
		in_valid_1 = go1;
		ins_1 = i1;
		idx_1 = x1;
		@(negedge clk);
		in_valid_0 = 1'b0;
		in_valid_1 = 1'b0;
	endtask

	task automatic finish_run(input bit timed_out);
		$display("checks failed: %0d, watchdog expired: %0d", dut_i.chk_i.fails, timed_out);
		if (dut_i.chk_i.fails == 0 && !timed_out)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	endtask

	// ==============================
	// Stimulus
	// ==============================

	initial
	begin
		logic [1:0] sel;
		logic [LINE_BITS-1:0] l;
		void'($urandom(SEED));
		clk = 1'b0;
		reset = 1'b1;
		wr_en = 1'b0;
		wr_idx = '0;
		wr_line = '0;
		in_valid_0 = 1'b0;
		in_valid_1 = 1'b0;
		ins_0 = '0;
		ins_1 = '0;
		idx_0 = '0;
		idx_1 = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Line 3 carries float values with exactly known widenings
		for (int n = 0; n < LINE_COUNT; n++)
		begin
			l = rand_line();
			if (n == 3)
				l[191:0] = {32'h0000_8000, 32'h8000_0000, 32'hc000_0000, 32'h3f80_0000,
					32'h0000_c000, 32'h0000_3c00};
			wr_en = 1'b1;
			wr_idx = LINE_IDX_BITS'(n);
			wr_line = l;
			@(negedge clk);
		end
		wr_en = 1'b0;

		// One of each class, then a contended pair
		issue(1, make_ins(OP_ADDI, 3'b000, 6'b11_10_01, 12'hf70), 2'd0, 0, '0, 2'd0);
		issue(0, '0, 2'd0, 1, make_ins(OP_XORI, 3'b001, 6'b00_01_10, 12'h3a4), 2'd1);
		issue(1, make_ins(OP_FLTI, 3'b000, 6'b10_01_01, 12'h210), 2'd3, 0, '0, 2'd0);
		issue(0, '0, 2'd0, 1, make_ins(OP_FLTI, 3'b010, 6'b01_10_10, 12'h543), 2'd3);
		issue(1, make_ins(OP_B0, 3'b011, 6'h2d, 12'h9c3), 2'd2, 0, '0, 2'd0);
		issue(0, '0, 2'd0, 1, make_ins(OP_BCC1, 3'b110, 6'h17, 12'h5e8), 2'd1);
		issue(1, make_ins(OP_LDW, 3'b001, 6'h3a, 12'hc21), 2'd0, 0, '0, 2'd0);
		issue(0, '0, 2'd0, 1, make_ins(OP_STI, 3'b010, 6'b00_10_01, 12'h0b4), 2'd2);
		issue(1, make_ins(OP_FENCE, 3'b000, 6'h15, 12'h7ff), 2'd0, 0, '0, 2'd0);
		issue(0, '0, 2'd0, 1, make_ins(OP_CSR, 3'b000, 6'h09, 12'h4d2), 2'd1);
		issue(1, make_ins(OP_MULI, 3'b000, 6'b10_10_11, 12'h8e1), 2'd2,
			1, make_ins(OP_FLTI, 3'b000, 6'b00_10_01, 12'h020), 2'd3);

		for (int r = 0; r < N_RANDOM; r++)
		begin
			sel = 2'($urandom);
			case (sel)
			2'd0:	issue(1, rand_ins(), 2'($urandom), 0, '0, 2'd0);
			2'd1:	issue(0, '0, 2'd0, 1, rand_ins(), 2'($urandom));
			default:	issue(1, rand_ins(), 2'($urandom), 1, rand_ins(), 2'($urandom));
			endcase
		end

		// Let the last results reach the checker
		while (busy_0 || busy_1)
			@(negedge clk);
		repeat (4) @(negedge clk);
		finish_run(0);
	end

	initial
	begin
		#(WATCH_CYCLES * 100);
		$display("Watchdog expired before all instructions were decoded");
		finish_run(1);
	end

endmodule
